// File: flist.f
design/cpu_pkg.sv
design/insn_if.sv
design/fetch_unit.sv
design/insn_queue.sv
design/execute_unit.sv
design/cpu_top.sv
testbench/apb_mem_model.sv
testbench/tb_cpu_top.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_top -f flist.f
	./obj_dir/Vtb_cpu_top > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES  = 320;
    localparam int NUM_TESTS    = 6;
    // every test gets its reset, its cycle budget and a little slack
    localparam int WATCHDOG_NS  = NUM_TESTS * (RESET_CYCLES + TEST_CYCLES + 10) * CLK_PERIOD;

    logic           clock;
    logic           rst_n;
    cpu_pkg::addr_t imem_paddr;
    logic           imem_psel;
    logic           imem_penable;
    cpu_pkg::word_t imem_prdata;
    logic           imem_pready;
    cpu_pkg::addr_t dmem_paddr;
    cpu_pkg::word_t dmem_pwdata;
    logic           dmem_psel;
    logic           dmem_penable;
    logic           dmem_pready;
    logic           halted;

    int             errors;
    int             checks;
    cpu_pkg::word_t prog [$];
    cpu_pkg::addr_t exp_addr [$];
    cpu_pkg::word_t exp_data [$];

    cpu_top uut (.*);

    apb_mem_model mem_model (.*);

    initial
        clock = 1'b0;

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic check_word(string name, cpu_pkg::word_t got, cpu_pkg::word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(string name, cpu_pkg::addr_t got, cpu_pkg::addr_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    function automatic cpu_pkg::word_t make_insn(cpu_pkg::opcode_t op, cpu_pkg::reg_idx_t dst,
        cpu_pkg::reg_idx_t a, cpu_pkg::reg_idx_t b, logic half, logic [31:0] imm);
        cpu_pkg::word_t w;
        w = '0;
        w[cpu_pkg::OPC_LSB +: cpu_pkg::OPC_W]   = op;
        w[cpu_pkg::SRC_A_LSB +: cpu_pkg::IDX_W] = a;
        w[cpu_pkg::SRC_B_LSB +: cpu_pkg::IDX_W] = b;
        w[cpu_pkg::DST_LSB +: cpu_pkg::IDX_W]   = dst;
        w[cpu_pkg::HALF_BIT]                    = half;
        w[cpu_pkg::IMM_LSB +: cpu_pkg::IMM_W]   = imm;
        return w;
    endfunction

    task automatic append_insn(cpu_pkg::opcode_t op, cpu_pkg::reg_idx_t dst,
        cpu_pkg::reg_idx_t a, cpu_pkg::reg_idx_t b, logic half, logic [31:0] imm);
        prog.push_back(make_insn(op, dst, a, b, half, imm));
    endtask

    // instruction-level model of the program that gives the expected store log
    task automatic run_model();
        cpu_pkg::word_t    regs [8];
        logic [7:0]        flags;
        cpu_pkg::addr_t    pc;
        cpu_pkg::word_t    w;
        cpu_pkg::opcode_t  op;
        cpu_pkg::reg_idx_t ia;
        cpu_pkg::reg_idx_t dst;
        cpu_pkg::word_t    va;
        cpu_pkg::word_t    vb;
        logic [31:0]       imm;
        logic              done;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 8; i++)
            regs[i] = '0;
        flags = '0;
        pc    = '0;
        done  = 1'b0;
        for (int step = 0; step < TEST_CYCLES && !done; step++)
        begin
            w   = (pc < prog.size()) ? prog[pc] : 64'd62;
            op  = w[cpu_pkg::OPC_LSB +: cpu_pkg::OPC_W];
            ia  = w[cpu_pkg::SRC_A_LSB +: cpu_pkg::IDX_W];
            dst = w[cpu_pkg::DST_LSB +: cpu_pkg::IDX_W];
            imm = w[cpu_pkg::IMM_LSB +: cpu_pkg::IMM_W];
            va  = regs[ia];
            vb  = regs[w[cpu_pkg::SRC_B_LSB +: cpu_pkg::IDX_W]];
            pc  = pc + 32'd1;
            case (op)
                cpu_pkg::OP_ADD: regs[dst] = va + vb;
                cpu_pkg::OP_SUB: regs[dst] = va - vb;
                cpu_pkg::OP_AND: regs[dst] = va & vb;
                cpu_pkg::OP_OR:  regs[dst] = va | vb;
                cpu_pkg::OP_XOR: regs[dst] = va ^ vb;
                cpu_pkg::OP_LDI:
                    regs[dst] = w[cpu_pkg::HALF_BIT] ? {imm, va[31:0]} : {va[63:32], imm};
                cpu_pkg::OP_SHL: regs[dst] = va << vb[5:0];
                cpu_pkg::OP_STORE:
                begin
                    exp_addr.push_back(va[31:0] + imm);
                    exp_data.push_back(vb);
                end
                cpu_pkg::OP_FEQ:  flags[dst] = (va == vb);
                cpu_pkg::OP_FLT:  flags[dst] = (va < vb);
                cpu_pkg::OP_BR:   pc = flags[ia] ? imm : pc;
                cpu_pkg::OP_JMP:  pc = imm;
                cpu_pkg::OP_HALT: done = 1'b1;
                default:          done = done;
            endcase
        end
    endtask

    task automatic start_program(input logic with_waits);
        @(posedge clock);
        #1;
        rst_n = 1'b0;
        mem_model.fill_memory();
        for (int i = 0; i < prog.size(); i++)
            mem_model.load_word(cpu_pkg::addr_t'(i), prog[i]);
        mem_model.wait_en = with_waits;
        repeat (RESET_CYCLES)
            @(posedge clock);
        #1;
        // both buses idle and no halt while reset is held
        check_bit("imem_psel", imem_psel, 1'b0);
        check_bit("imem_penable", imem_penable, 1'b0);
        check_bit("dmem_psel", dmem_psel, 1'b0);
        check_bit("dmem_penable", dmem_penable, 1'b0);
        check_bit("halted", halted, 1'b0);
        mem_model.clear_logs();
        rst_n = 1'b1;
    endtask

    task automatic wait_halted();
        int n;
        n = 0;
        while (!halted && n < TEST_CYCLES)
        begin
            @(posedge clock);
            #1;
            n++;
        end
        if (!halted)
        begin
            errors++;
            $display("core did not halt within %0d cycles", TEST_CYCLES);
        end
    endtask

    task automatic compare_log();
        int n;
        run_model();
        check_count("dmem write count", mem_model.wr_addr.size(), exp_addr.size());
        n = (mem_model.wr_addr.size() < exp_addr.size()) ? mem_model.wr_addr.size()
                                                          : exp_addr.size();
        for (int i = 0; i < n; i++)
        begin
            check_addr($sformatf("dmem_paddr[%0d]", i), mem_model.wr_addr[i], exp_addr[i]);
            check_word($sformatf("dmem_pwdata[%0d]", i), mem_model.wr_data[i], exp_data[i]);
        end
    endtask

    task automatic build_alu_program();
        cpu_pkg::opcode_t ops [6];
        ops = '{cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
                cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_SHL};
        prog.delete();
        append_insn(cpu_pkg::OP_LDI, 1, 0, 0, 0, 32'h9abc_def0);
        append_insn(cpu_pkg::OP_LDI, 1, 1, 0, 1, 32'h1234_5678);
        append_insn(cpu_pkg::OP_LDI, 2, 0, 0, 0, 32'hffff_0000);
        append_insn(cpu_pkg::OP_LDI, 2, 2, 0, 1, 32'h0f0f_0f0f);
        // low 6 bits give a shift of 4 and the upper bits must be ignored
        append_insn(cpu_pkg::OP_LDI, 3, 0, 0, 0, 32'h0000_0144);
        append_insn(cpu_pkg::OP_LDI, 7, 0, 0, 0, 32'h0000_0100);
        for (int i = 0; i < 6; i++)
        begin
            append_insn(ops[i], 4, 1, (ops[i] == cpu_pkg::OP_SHL) ? 3'd3 : 3'd2, 0, 0);
            append_insn(cpu_pkg::OP_STORE, 0, 7, 4, 0, i);
        end
        append_insn(cpu_pkg::OP_HALT, 0, 0, 0, 0, 0);
    endtask

    task automatic test_fetch_nops();
        prog.delete();
        start_program(1'b0);
        repeat (40)
        begin
            @(posedge clock);
            #1;
            check_bit("dmem_psel", dmem_psel, 1'b0);
            check_bit("halted", halted, 1'b0);
        end
        if (mem_model.rd_addr.size() < 5)
        begin
            errors++;
            $display("only %0d instruction fetches in 40 cycles", mem_model.rd_addr.size());
        end
        for (int i = 0; i < mem_model.rd_addr.size(); i++)
            check_addr("imem_paddr", mem_model.rd_addr[i], cpu_pkg::addr_t'(i));
        check_count("dmem write count", mem_model.wr_addr.size(), 0);
    endtask

    task automatic test_alu(input logic with_waits);
        build_alu_program();
        start_program(with_waits);
        wait_halted();
        compare_log();
    endtask

    task automatic test_store_addr();
        prog.delete();
        append_insn(cpu_pkg::OP_LDI, 7, 0, 0, 0, 32'h0000_0200);
        append_insn(cpu_pkg::OP_LDI, 7, 7, 0, 1, 32'hdead_beef);
        append_insn(cpu_pkg::OP_LDI, 1, 0, 0, 0, 32'h0000_1111);
        append_insn(cpu_pkg::OP_LDI, 2, 0, 0, 1, 32'hcafe_f00d);
        append_insn(cpu_pkg::OP_STORE, 0, 7, 1, 0, 32'h0000_0005);
        append_insn(cpu_pkg::OP_STORE, 0, 7, 2, 0, 32'h0000_0006);
        append_insn(cpu_pkg::OP_STORE, 0, 7, 7, 0, 32'hffff_fff0);
        append_insn(cpu_pkg::OP_STORE, 0, 1, 7, 0, 32'h0000_0040);
        append_insn(cpu_pkg::OP_HALT, 0, 0, 0, 0, 0);
        start_program(1'b0);
        wait_halted();
        compare_log();
    endtask

    task automatic test_control_flow();
        prog.delete();
        append_insn(cpu_pkg::OP_LDI, 1, 0, 0, 0, 5);
        append_insn(cpu_pkg::OP_LDI, 2, 0, 0, 0, 5);
        // top bit set so that flag less must compare unsigned
        append_insn(cpu_pkg::OP_LDI, 3, 0, 0, 1, 32'h8000_0000);
        append_insn(cpu_pkg::OP_FEQ, 1, 1, 2, 0, 0);
        append_insn(cpu_pkg::OP_FEQ, 2, 1, 3, 0, 0);
        append_insn(cpu_pkg::OP_FLT, 3, 1, 3, 0, 0);
        append_insn(cpu_pkg::OP_FLT, 4, 3, 1, 0, 0);
        append_insn(cpu_pkg::OP_BR, 0, 1, 0, 0, 9);
        append_insn(cpu_pkg::OP_STORE, 0, 0, 3, 0, 32'h10);
        append_insn(cpu_pkg::OP_STORE, 0, 0, 1, 0, 32'h11);
        append_insn(cpu_pkg::OP_BR, 0, 2, 0, 0, 12);
        append_insn(cpu_pkg::OP_STORE, 0, 0, 2, 0, 32'h12);
        append_insn(cpu_pkg::OP_BR, 0, 3, 0, 0, 14);
        append_insn(cpu_pkg::OP_STORE, 0, 0, 3, 0, 32'h13);
        append_insn(cpu_pkg::OP_BR, 0, 4, 0, 0, 16);
        append_insn(cpu_pkg::OP_STORE, 0, 0, 3, 0, 32'h14);
        append_insn(cpu_pkg::OP_JMP, 0, 0, 0, 0, 18);
        append_insn(cpu_pkg::OP_STORE, 0, 0, 1, 0, 32'h15);
        // clears flag 1 again
        append_insn(cpu_pkg::OP_FEQ, 1, 1, 3, 0, 0);
        append_insn(cpu_pkg::OP_BR, 0, 1, 0, 0, 21);
        append_insn(cpu_pkg::OP_STORE, 0, 0, 2, 0, 32'h16);
        append_insn(cpu_pkg::OP_HALT, 0, 0, 0, 0, 0);
        start_program(1'b0);
        wait_halted();
        compare_log();
    endtask

    task automatic test_halt();
        prog.delete();
        append_insn(cpu_pkg::OP_LDI, 1, 0, 0, 0, 32'h77);
        append_insn(cpu_pkg::OP_STORE, 0, 0, 1, 0, 32'h20);
        append_insn(cpu_pkg::OP_HALT, 0, 0, 0, 0, 0);
        append_insn(cpu_pkg::OP_STORE, 0, 0, 1, 0, 32'h21);
        append_insn(cpu_pkg::OP_LDI, 2, 0, 0, 0, 32'h1);
        append_insn(cpu_pkg::OP_STORE, 0, 0, 2, 0, 32'h22);
        start_program(1'b1);
        wait_halted();
        repeat (50)
        begin
            @(posedge clock);
            #1;
            check_bit("halted", halted, 1'b1);
            check_bit("dmem_psel", dmem_psel, 1'b0);
        end
        compare_log();
    endtask

    initial
    begin
        errors = 0;
        checks = 0;
        rst_n  = 1'b0;
        test_fetch_nops();
        test_alu(1'b0);
        test_store_addr();
        test_control_flow();
        // same program with wait states on both ports
        test_alu(1'b1);
        test_halt();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/apb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module apb_mem_model (
    input  logic           clock,
    input  cpu_pkg::addr_t imem_paddr,
    input  logic           imem_psel,
    input  logic           imem_penable,
    output cpu_pkg::word_t imem_prdata,
    output logic           imem_pready,
    input  cpu_pkg::addr_t dmem_paddr,
    input  cpu_pkg::word_t dmem_pwdata,
    input  logic           dmem_psel,
    input  logic           dmem_penable,
    output logic           dmem_pready
);

    localparam int IMEM_WORDS = 256;

    cpu_pkg::word_t imem [IMEM_WORDS];
    cpu_pkg::addr_t rd_addr [$];
    cpu_pkg::addr_t wr_addr [$];
    cpu_pkg::word_t wr_data [$];
    logic           wait_en;
    integer         seed;
    int             imem_wait;
    int             dmem_wait;

    // unused words decode as no-ops (opcode 62) carrying their own address
    function automatic cpu_pkg::word_t fill_word(cpu_pkg::addr_t addr);
        return {addr, 26'd0, 6'd62};
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = fill_word(cpu_pkg::addr_t'(i));
    endtask

    task automatic load_word(cpu_pkg::addr_t addr, cpu_pkg::word_t data);
        imem[addr[7:0]] = data;
    endtask

    task automatic clear_logs();
        rd_addr.delete();
        wr_addr.delete();
        wr_data.delete();
    endtask

    assign imem_prdata = (imem_paddr < IMEM_WORDS) ? imem[imem_paddr[7:0]]
                                                   : fill_word(imem_paddr);

    initial
    begin
        wait_en     = 1'b0;
        seed        = 32'hb731;
        imem_wait   = 0;
        dmem_wait   = 0;
        imem_pready = 1'b0;
        dmem_pready = 1'b0;
        fill_memory();
    end

    // both ports in one process so the random sequence has a fixed order
    always @(posedge clock)
    begin
        #1;
        if (imem_psel && !imem_penable)
            imem_wait = wait_en ? ($unsigned($random(seed)) % 4) : 0;
        if (dmem_psel && !dmem_penable)
            dmem_wait = wait_en ? ($unsigned($random(seed)) % 4) : 0;

        imem_pready = 1'b0;
        if (imem_psel && imem_penable)
        begin
            if (imem_wait == 0)
            begin
                imem_pready = 1'b1;
                rd_addr.push_back(imem_paddr);
            end
            else
            begin
                imem_wait--;
            end
        end

        // a write is logged once pready is up, it completes on the next edge
        dmem_pready = 1'b0;
        if (dmem_psel && dmem_penable)
        begin
            if (dmem_wait == 0)
            begin
                dmem_pready = 1'b1;
                wr_addr.push_back(dmem_paddr);
                wr_data.push_back(dmem_pwdata);
            end
            else
            begin
                dmem_wait--;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic           clock,
    input  logic           rst_n,
    output cpu_pkg::addr_t imem_paddr,
    output logic           imem_psel,
    output logic           imem_penable,
    input  cpu_pkg::word_t imem_prdata,
    input  logic           imem_pready,
    output cpu_pkg::addr_t dmem_paddr,
    output cpu_pkg::word_t dmem_pwdata,
    output logic           dmem_psel,
    output logic           dmem_penable,
    input  logic           dmem_pready,
    output logic           halted
);

    logic           redirect;
    cpu_pkg::addr_t redirect_pc;

    insn_if fetch_to_queue ();
    insn_if queue_to_exec ();

    fetch_unit u_fetch (
        .clock        (clock),
        .rst_n        (rst_n),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .out          (fetch_to_queue.source),
        .imem_paddr   (imem_paddr),
        .imem_psel    (imem_psel),
        .imem_penable (imem_penable),
        .imem_prdata  (imem_prdata),
        .imem_pready  (imem_pready)
    );

    insn_queue u_queue (
        .clock    (clock),
        .rst_n    (rst_n),
        .redirect (redirect),
        .in       (fetch_to_queue.sink),
        .out      (queue_to_exec.source)
    );

    execute_unit u_exec (
        .clock        (clock),
        .rst_n        (rst_n),
        .in           (queue_to_exec.sink),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .dmem_paddr   (dmem_paddr),
        .dmem_pwdata  (dmem_pwdata),
        .dmem_psel    (dmem_psel),
        .dmem_penable (dmem_penable),
        .dmem_pready  (dmem_pready),
        .halted       (halted)
    );

endmodule

`default_nettype wire

// File: design/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic           clock,
    input  logic           rst_n,
    insn_if.sink           in,
    output logic           redirect,
    output cpu_pkg::addr_t redirect_pc,
    output cpu_pkg::addr_t dmem_paddr,
    output cpu_pkg::word_t dmem_pwdata,
    output logic           dmem_psel,
    output logic           dmem_penable,
    input  logic           dmem_pready,
    output logic           halted
);

    cpu_pkg::exec_state_t state;
    cpu_pkg::word_t       regs [2**cpu_pkg::IDX_W];
    logic [2**cpu_pkg::IDX_W-1:0] flags;

    cpu_pkg::opcode_t  opcode;
    cpu_pkg::reg_idx_t src_a;
    cpu_pkg::reg_idx_t src_b;
    cpu_pkg::reg_idx_t dst;
    logic              half;
    logic [cpu_pkg::IMM_W-1:0] imm;

    cpu_pkg::word_t op_a;
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t result;
    logic           flag_a;
    logic           accept;
    logic           reg_we;
    logic           flag_we;
    logic           take;
    cpu_pkg::addr_t expect_pc;

    function automatic cpu_pkg::word_t alu(
        input cpu_pkg::opcode_t          op,
        input cpu_pkg::word_t            a,
        input cpu_pkg::word_t            b,
        input logic [cpu_pkg::IMM_W-1:0] k,
        input logic                      hi
    );
        cpu_pkg::word_t r;
        r = '0;
        case (op)
            cpu_pkg::OP_ADD: r = a + b;
            cpu_pkg::OP_SUB: r = a - b;
            cpu_pkg::OP_AND: r = a & b;
            cpu_pkg::OP_OR:  r = a | b;
            cpu_pkg::OP_XOR: r = a ^ b;
            // other half of a passes through unchanged
            cpu_pkg::OP_LDI: r = hi ? {k, a[31:0]} : {a[63:32], k};
            cpu_pkg::OP_SHL: r = a << b[5:0];
            cpu_pkg::OP_FEQ: r = cpu_pkg::word_t'(a == b);
            cpu_pkg::OP_FLT: r = cpu_pkg::word_t'(a < b);
            default:         r = '0;
        endcase
        return r;
    endfunction

    // field decode
    assign opcode = in.insn[cpu_pkg::OPC_LSB +: cpu_pkg::OPC_W];
    assign src_a  = in.insn[cpu_pkg::SRC_A_LSB +: cpu_pkg::IDX_W];
    assign src_b  = in.insn[cpu_pkg::SRC_B_LSB +: cpu_pkg::IDX_W];
    assign dst    = in.insn[cpu_pkg::DST_LSB +: cpu_pkg::IDX_W];
    assign half   = in.insn[cpu_pkg::HALF_BIT];
    assign imm    = in.insn[cpu_pkg::IMM_LSB +: cpu_pkg::IMM_W];

    assign op_a   = regs[src_a];
    assign op_b   = regs[src_b];
    assign flag_a = flags[src_a];
    assign result = alu(opcode, op_a, op_b, imm, half);

    // no accept while a redirect is out, the next queue entry is a wrong-path one
    assign in.ready = (state == cpu_pkg::EXEC_RUN) && !redirect;
    assign accept   = in.valid && in.ready;

    assign reg_we  = accept && (opcode <= cpu_pkg::OP_SHL);
    assign flag_we = accept && ((opcode == cpu_pkg::OP_FEQ) || (opcode == cpu_pkg::OP_FLT));
    assign take    = accept && ((opcode == cpu_pkg::OP_JMP) ||
                                ((opcode == cpu_pkg::OP_BR) && flag_a));

    assign dmem_psel    = (state == cpu_pkg::EXEC_STORE_SETUP) ||
                          (state == cpu_pkg::EXEC_STORE_ACCESS);
    assign dmem_penable = (state == cpu_pkg::EXEC_STORE_ACCESS);
    assign halted       = (state == cpu_pkg::EXEC_HALTED);

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            state     <= cpu_pkg::EXEC_RUN;
            redirect  <= 1'b0;
            flags     <= '0;
            expect_pc <= '0;
            for (int i = 0; i < 2**cpu_pkg::IDX_W; i++)
                regs[i] <= '0;
        end
        else
        begin
            redirect <= take;
            if (reg_we)
                regs[dst] <= result;
            if (flag_we)
                flags[dst] <= result[0];
            if (accept)
                expect_pc <= take ? cpu_pkg::addr_t'(imm) : in.pc + 32'd1;

            case (state)
                cpu_pkg::EXEC_RUN:
                begin
                    if (accept && (opcode == cpu_pkg::OP_STORE))
                        state <= cpu_pkg::EXEC_STORE_SETUP;
                    else if (accept && (opcode == cpu_pkg::OP_HALT))
                        state <= cpu_pkg::EXEC_HALTED;
                end
                cpu_pkg::EXEC_STORE_SETUP:
                    state <= cpu_pkg::EXEC_STORE_ACCESS;
                cpu_pkg::EXEC_STORE_ACCESS:
                begin
                    if (dmem_pready)
                        state <= cpu_pkg::EXEC_RUN;
                end
                default:
                    state <= cpu_pkg::EXEC_HALTED;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (take)
            redirect_pc <= cpu_pkg::addr_t'(imm);
        if (accept && (opcode == cpu_pkg::OP_STORE))
        begin
            dmem_paddr  <= op_a[31:0] + imm;
            dmem_pwdata <= op_b;
        end
    end

    a_redirect_not_in_store: assert property (@(posedge clock) disable iff (!rst_n)
        redirect |-> !dmem_psel);

    // fetch and queue together must deliver the program in order, nothing lost or repeated
    a_insn_order: assert property (@(posedge clock) disable iff (!rst_n)
        accept |-> (in.pc == expect_pc));

endmodule

`default_nettype wire

// File: design/insn_queue.sv
`timescale 1ns/1ps
`default_nettype none

module insn_queue (
    input  logic   clock,
    input  logic   rst_n,
    input  logic   redirect,
    insn_if.sink   in,
    insn_if.source out
);

    cpu_pkg::word_t      insn_mem [cpu_pkg::QUEUE_DEPTH];
    cpu_pkg::addr_t      pc_mem   [cpu_pkg::QUEUE_DEPTH];
    cpu_pkg::queue_ptr_t wr_ptr;
    cpu_pkg::queue_ptr_t rd_ptr;
    cpu_pkg::queue_cnt_t count;
    logic                full;
    logic                empty;
    logic                push;
    logic                pop;

    assign full  = (count == cpu_pkg::queue_cnt_t'(cpu_pkg::QUEUE_DEPTH));
    assign empty = (count == '0);
    assign push  = in.valid && !full;
    assign pop   = out.ready && !empty;

    assign in.ready  = !full;
    assign out.valid = !empty;
    assign out.insn  = insn_mem[rd_ptr];
    assign out.pc    = pc_mem[rd_ptr];

    // depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clock)
    begin
        if (!rst_n || redirect)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (push && !redirect)
        begin
            insn_mem[wr_ptr] <= in.insn;
            pc_mem[wr_ptr]   <= in.pc;
        end
    end

    a_count_bound: assert property (@(posedge clock) disable iff (!rst_n)
        count <= cpu_pkg::queue_cnt_t'(cpu_pkg::QUEUE_DEPTH));

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           redirect,
    input  cpu_pkg::addr_t redirect_pc,
    insn_if.source         out,
    output cpu_pkg::addr_t imem_paddr,
    output logic           imem_psel,
    output logic           imem_penable,
    input  cpu_pkg::word_t imem_prdata,
    input  logic           imem_pready
);

    cpu_pkg::fetch_state_t state;
    cpu_pkg::addr_t        fetch_pc;
    cpu_pkg::addr_t        pend_pc;
    cpu_pkg::word_t        insn_q;
    logic                  discard;
    logic                  rd_busy;
    logic                  rd_done;

    assign rd_busy = (state == cpu_pkg::FETCH_SETUP) || (state == cpu_pkg::FETCH_ACCESS);
    assign rd_done = (state == cpu_pkg::FETCH_ACCESS) && imem_pready;

    assign imem_paddr   = fetch_pc;
    assign imem_psel    = rd_busy;
    assign imem_penable = (state == cpu_pkg::FETCH_ACCESS);

    assign out.valid = (state == cpu_pkg::FETCH_HOLD);
    assign out.insn  = insn_q;
    assign out.pc    = fetch_pc;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            state    <= cpu_pkg::FETCH_IDLE;
            fetch_pc <= '0;
            discard  <= 1'b0;
        end
        else
        begin
            case (state)
                cpu_pkg::FETCH_IDLE:
                begin
                    if (redirect)
                        fetch_pc <= redirect_pc;
                    state <= cpu_pkg::FETCH_SETUP;
                end
                cpu_pkg::FETCH_SETUP:
                begin
                    // the address must not move mid-transfer, so only note the redirect
                    if (redirect)
                        discard <= 1'b1;
                    state <= cpu_pkg::FETCH_ACCESS;
                end
                cpu_pkg::FETCH_ACCESS:
                begin
                    if (imem_pready)
                    begin
                        if (redirect || discard)
                        begin
                            fetch_pc <= redirect ? redirect_pc : pend_pc;
                            discard  <= 1'b0;
                            state    <= cpu_pkg::FETCH_SETUP;
                        end
                        else
                        begin
                            state <= cpu_pkg::FETCH_HOLD;
                        end
                    end
                    else if (redirect)
                    begin
                        discard <= 1'b1;
                    end
                end
                cpu_pkg::FETCH_HOLD:
                begin
                    // redirect drops the held word even if the queue takes it
                    if (redirect)
                    begin
                        fetch_pc <= redirect_pc;
                        state    <= cpu_pkg::FETCH_SETUP;
                    end
                    else if (out.ready)
                    begin
                        fetch_pc <= fetch_pc + 32'd1;
                        state    <= cpu_pkg::FETCH_SETUP;
                    end
                end
                default:
                    state <= cpu_pkg::FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (redirect && rd_busy)
            pend_pc <= redirect_pc;
        if (rd_done)
            insn_q <= imem_prdata;
    end

    a_penable_needs_psel: assert property (@(posedge clock) disable iff (!rst_n)
        imem_penable |-> imem_psel);

    a_paddr_stable: assert property (@(posedge clock) disable iff (!rst_n)
        imem_psel && !(imem_penable && imem_pready) |=> $stable(imem_paddr));

endmodule

`default_nettype wire

// File: design/insn_if.sv
`timescale 1ns/1ps
`default_nettype none

// instruction handoff between stages, valid/ready
interface insn_if;

    logic           valid;
    logic           ready;
    cpu_pkg::word_t insn;
    cpu_pkg::addr_t pc;

    modport source (output valid, output insn, output pc, input ready);

    modport sink (input valid, input insn, input pc, output ready);

endinterface

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [63:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;

    // instruction word layout
    localparam int OPC_LSB   = 0;
    localparam int OPC_W     = 6;
    localparam int SRC_A_LSB = 6;
    localparam int SRC_B_LSB = 9;
    localparam int DST_LSB   = 12;
    localparam int IDX_W     = 3;
    localparam int HALF_BIT  = 15;
    localparam int IMM_LSB   = 32;
    localparam int IMM_W     = 32;

    localparam opcode_t OP_ADD   = 6'd0;
    localparam opcode_t OP_SUB   = 6'd1;
    localparam opcode_t OP_AND   = 6'd2;
    localparam opcode_t OP_OR    = 6'd3;
    localparam opcode_t OP_XOR   = 6'd4;
    localparam opcode_t OP_LDI   = 6'd5;
    localparam opcode_t OP_SHL   = 6'd6;
    localparam opcode_t OP_STORE = 6'd7;
    localparam opcode_t OP_FEQ   = 6'd8;
    localparam opcode_t OP_FLT   = 6'd9;
    localparam opcode_t OP_BR    = 6'd10;
    localparam opcode_t OP_JMP   = 6'd11;
    localparam opcode_t OP_HALT  = 6'd63;

    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;
    typedef logic [QUEUE_PTR_W:0]   queue_cnt_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_SETUP,
        FETCH_ACCESS,
        FETCH_HOLD
    } fetch_state_t;

    typedef enum logic [1:0] {
        EXEC_RUN,
        EXEC_STORE_SETUP,
        EXEC_STORE_ACCESS,
        EXEC_HALTED
    } exec_state_t;

endpackage

`default_nettype wire
